// ==== bitSampler.sv ====
module bitSampler import canProtocolPkg::*, replayPkg::*; (
	input logic clk,
	input logic resetN,
	input logic canRx,
	input period_t bitPeriod,
	input logic override,
	output logic rxBit,
	output logic samplePulse
);

	logic syncA;
	logic syncB;
	logic prevBit;
	logic fallingEdge;
	period_t phaseCount;

	// Resync on recessive to dominant, but not while we drive the bus
	assign fallingEdge = (prevBit == recessive) && (syncB == dominant) && !override;

	// Two-stage synchronizer plus edge history
	always_ff @(posedge clk) begin
		if (!resetN) begin
			syncA <= recessive;
			syncB <= recessive;
			prevBit <= recessive;
		end else begin
			syncA <= canRx;
			syncB <= syncA;
			prevBit <= syncB;
		end
	end

	// Phase counter counts down to the sample point
	always_ff @(posedge clk) begin
		if (!resetN) begin
			phaseCount <= '0;
			samplePulse <= 1'b0;
			rxBit <= recessive;
		end else begin
			samplePulse <= 1'b0;
			if (fallingEdge) begin
				// Half a bit to the middle of the new bit
				phaseCount <= bitPeriod >> 1;
			end else if (phaseCount == '0) begin
				phaseCount <= bitPeriod - 1'b1;
				samplePulse <= 1'b1;
				rxBit <= syncB;
			end else begin
				phaseCount <= phaseCount - 1'b1;
			end
		end
	end

endmodule

// ==== canProtocolPkg.sv ====
package canProtocolPkg;

	////////////////////////////////////////////////////////////
	// Frame field lengths, in bit times
	////////////////////////////////////////////////////////////

	// Standard 11-bit identifier
	localparam int idBits = 11;

	// Recessive bits that count as an idle gap between frames
	localparam int interframeBits = 11;

	// Six dominant bits in a row form an error flag
	localparam int errorFlagBits = 6;

	// Bit times watched after playback before accepting
	localparam int errorWindowBits = 9;

	// Bus levels, wired-AND so dominant wins
	localparam logic recessive = 1'b1;
	localparam logic dominant = 1'b0;

	typedef logic [idBits-1:0] canId_t;

endpackage

// ==== compile.f ====
canProtocolPkg.sv
replayPkg.sv
bitSampler.sv
runDetector.sv
idComparator.sv
playbackUnit.sv
replaySequencer.sv
sampleReplayTop.sv
sampleReplay_sva.sv
sampleReplayTb.sv

// ==== idComparator.sv ====
module idComparator import canProtocolPkg::*; (
	input logic clk,
	input logic resetN,
	input logic start,
	input logic rxBit,
	input logic samplePulse,
	input canId_t canId,
	output logic done,
	output logic match
);

	localparam int countWidth = $clog2(idBits + 1);
	localparam logic [countWidth-1:0] lastBit = countWidth'(idBits - 1);

	logic active;
	logic matchHeld;
	logic [countWidth-1:0] bitCount;
	canId_t shiftReg;
	canId_t nextId;

	assign nextId = {shiftReg[idBits-2:0], rxBit};

	// Decision lands on the sample of the last ID bit
	assign done = active && samplePulse && (bitCount == lastBit);
	assign match = done ? (nextId == canId) : matchHeld;

	always_ff @(posedge clk) begin
		if (!resetN) begin
			active <= 1'b0;
			bitCount <= '0;
			matchHeld <= 1'b0;
		end else if (start) begin
			active <= 1'b1;
			bitCount <= '0;
			matchHeld <= 1'b0;
		end else if (active && samplePulse) begin
			bitCount <= bitCount + 1'b1;
			if (done) begin
				active <= 1'b0;
				matchHeld <= match;
			end
		end
	end

	// MSB arrives first
	always_ff @(posedge clk) begin
		if (active && samplePulse) begin
			shiftReg <= nextId;
		end
	end

endmodule

// ==== playbackUnit.sv ====
module playbackUnit import canProtocolPkg::*, replayPkg::*; (
	input logic clk,
	input logic resetN,
	input logic start,
	input memAddr_t baseAddr,
	input wordCount_t sigWords,
	input period_t playbackPeriod,
	input word_t readData,
	output logic rdEn,
	output memAddr_t addr,
	output logic sampleOut,
	output logic outSwitch,
	output logic done
);

	localparam int bitIdxWidth = $clog2(wordWidth);
	localparam logic [bitIdxWidth-1:0] lastBit = bitIdxWidth'(wordWidth - 1);

	logic firstLoad;
	logic holdOne;
	logic bitEnd;
	logic wordEnd;
	logic preEnd;
	logic [bitIdxWidth-1:0] bitIndex;
	period_t holdLast;
	period_t periodCount;
	wordCount_t wordsLeft;
	memAddr_t nextAddr;
	word_t shiftReg;

	////////////////////////////////////////////////////////////
	// Bit timing and prefetch
	////////////////////////////////////////////////////////////

	// A period of 0 plays at one bit per clock
	assign holdOne = (playbackPeriod <= period_t'(1));
	assign holdLast = holdOne ? '0 : playbackPeriod - period_t'(1);

	assign bitEnd = outSwitch && (periodCount == '0);
	assign wordEnd = bitEnd && (bitIndex == lastBit);

	// Cycle just before the word runs out, so readData lands on time
	assign preEnd = outSwitch && (holdOne ? (bitIndex == lastBit - 1'b1) :
		(bitIndex == lastBit && periodCount == period_t'(1)));

	assign rdEn = start || (preEnd && wordsLeft != '0);
	assign addr = start ? baseAddr : nextAddr;
	assign sampleOut = outSwitch ? shiftReg[wordWidth-1] : recessive;

	always_ff @(posedge clk) begin
		if (!resetN) begin
			firstLoad <= 1'b0;
			outSwitch <= 1'b0;
			done <= 1'b0;
			bitIndex <= '0;
			periodCount <= '0;
			wordsLeft <= '0;
			nextAddr <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				firstLoad <= 1'b1;
				outSwitch <= 1'b0;
				nextAddr <= baseAddr + 1'b1;
			end else if (firstLoad) begin
				firstLoad <= 1'b0;
				outSwitch <= 1'b1;
				bitIndex <= '0;
				periodCount <= holdLast;
				wordsLeft <= sigWords - 1'b1;
			end else if (outSwitch) begin
				if (rdEn) begin
					nextAddr <= nextAddr + 1'b1;
				end
				if (!bitEnd) begin
					periodCount <= periodCount - 1'b1;
				end else begin
					periodCount <= holdLast;
					bitIndex <= bitIndex + 1'b1;
					if (wordEnd && wordsLeft == '0) begin
						outSwitch <= 1'b0;
						done <= 1'b1;
					end else if (wordEnd) begin
						wordsLeft <= wordsLeft - 1'b1;
					end
				end
			end
		end
	end

	// Word shift register, MSB goes out first
	always_ff @(posedge clk) begin
		if (firstLoad || (wordEnd && wordsLeft != '0)) begin
			shiftReg <= readData;
		end else if (bitEnd) begin
			shiftReg <= {shiftReg[wordWidth-2:0], 1'b0};
		end
	end

endmodule

// ==== replayPkg.sv ====
package replayPkg;

	////////////////////////////////////////////////////////////
	// Replay memory and configuration types
	////////////////////////////////////////////////////////////

	localparam int wordWidth = 32;

	// Word memory, 32k words deep
	typedef logic [14:0] memAddr_t;
	typedef logic [wordWidth-1:0] word_t;

	// Bit and playback periods in clock cycles
	typedef logic [23:0] period_t;

	// Signal count and index
	typedef logic [15:0] sigIndex_t;

	// Words per stored signal
	typedef logic [15:0] wordCount_t;

endpackage

// ==== replaySequencer.sv ====
module replaySequencer import canProtocolPkg::*, replayPkg::*; #(
	parameter int dataOffsetBits = 16
) (
	input logic clk,
	input logic resetN,
	input logic enable,
	input sigIndex_t numSigs,
	input wordCount_t sigWords,
	input logic samplePulse,
	input logic rxBit,
	input logic idleRun,
	input logic errorRun,
	input logic idDone,
	input logic idMatch,
	input logic playDone,
	output logic idStart,
	output logic runClear,
	output logic playStart,
	output logic override,
	output memAddr_t baseAddr,
	output sigIndex_t validSigNum,
	output logic invalidSignal,
	output logic interrupt
);

	typedef enum logic [2:0] {
		idle,
		waitGap,
		waitSof,
		compare,
		waitData,
		play,
		checkError,
		report
	} state_t;

	state_t state;
	state_t nextState;
	logic [15:0] bitCount;
	sigIndex_t sigIndex;
	sigIndex_t nextIndex;
	logic offsetDone;
	logic windowDone;
	logic lastSig;

	assign offsetDone = samplePulse && (bitCount == 16'(dataOffsetBits - 1));
	assign windowDone = (bitCount == 16'(errorWindowBits));
	assign nextIndex = sigIndex + 1'b1;
	assign lastSig = (nextIndex >= numSigs);

	////////////////////////////////////////////////////////////
	// Strobes, taken on the transitions
	////////////////////////////////////////////////////////////

	// SOF is the first dominant sample after the gap
	assign idStart = (state == waitSof) && samplePulse && (rxBit == dominant);
	assign playStart = (state == waitData) && offsetDone;
	assign runClear = (state == play) && playDone;

	// No resync on our own edges
	assign override = (state == play);
	assign interrupt = (state == report);

	////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetN || !enable) begin
			state <= idle;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			idle: begin
				nextState = waitGap;
			end
			waitGap: begin
				if (idleRun) begin
					nextState = waitSof;
				end
			end
			waitSof: begin
				if (idStart) begin
					nextState = compare;
				end
			end
			compare: begin
				if (idDone) begin
					nextState = idMatch ? waitData : waitGap;
				end
			end
			waitData: begin
				if (playStart) begin
					nextState = play;
				end
			end
			play: begin
				if (playDone) begin
					nextState = checkError;
				end
			end
			checkError: begin
				// Error flag rejects the signal, try the next one
				if (errorRun) begin
					nextState = lastSig ? report : waitGap;
				end else if (windowDone) begin
					nextState = report;
				end
			end
			default: begin
				nextState = state;
			end
		endcase
	end

	// Bit counter, signal index and result
	always_ff @(posedge clk) begin
		if (!resetN || !enable) begin
			bitCount <= '0;
			sigIndex <= '0;
			baseAddr <= '0;
			validSigNum <= '0;
			invalidSignal <= 1'b0;
		end else begin
			if (state != nextState) begin
				bitCount <= '0;
			end else if (samplePulse) begin
				bitCount <= bitCount + 1'b1;
			end
			if (state == checkError && errorRun) begin
				sigIndex <= nextIndex;
				baseAddr <= baseAddr + memAddr_t'(sigWords);
				invalidSignal <= lastSig;
			end else if (state == checkError && windowDone) begin
				validSigNum <= sigIndex;
			end
		end
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the CAN replay testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
	--top-module sampleReplayTb -f compile.f -o simv
status=$?
if [ $status -ne 0 ]; then
	echo "Build failed with status $status"
	exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Verification passed" "$LOG"; then
	exit 0
fi
exit 1

// ==== runDetector.sv ====
module runDetector #(
	parameter int runLength = 11,
	parameter logic runLevel = 1'b1
) (
	input logic clk,
	input logic resetN,
	input logic clear,
	input logic rxBit,
	input logic samplePulse,
	output logic run
);

	localparam int countWidth = $clog2(runLength + 1);
	localparam logic [countWidth-1:0] fullCount = countWidth'(runLength);

	logic [countWidth-1:0] runCount;

	// Saturates, so run stays up while the level holds
	assign run = (runCount == fullCount);

	always_ff @(posedge clk) begin
		if (!resetN || clear) begin
			runCount <= '0;
		end else if (samplePulse) begin
			if (rxBit != runLevel) begin
				runCount <= '0;
			end else if (runCount != fullCount) begin
				runCount <= runCount + 1'b1;
			end
		end
	end

endmodule

// ==== sampleReplayTb.sv ====
module sampleReplayTb import canProtocolPkg::*, replayPkg::*;;

	typedef struct {
		canId_t id;
		sigIndex_t numSigs;
		wordCount_t sigWords;
		period_t bitPeriod;
		period_t playbackPeriod;
		int decoys;
		logic [15:0] acceptMask;
	} row_t;

	localparam int numRows = 3;
	localparam int fillerBits = 20;
	localparam int frameBits = 11 + 1 + idBits + fillerBits;

	logic clk;
	logic resetN;
	logic enable;
	logic canRx;
	logic nodeBit;
	canId_t canId;
	period_t bitPeriod;
	period_t playbackPeriod;
	wordCount_t sigWords;
	sigIndex_t numSigs;
	word_t readData;
	logic sampleOut;
	logic outSwitch;
	logic rdEn;
	memAddr_t addr;
	sigIndex_t validSigNum;
	logic invalidSignal;
	logic interrupt;

	word_t mem [0:32767];
	row_t rows [numRows];
	logic rdPending;
	memAddr_t rdAddr;
	int errors;
	int passedRows;
	int cycles;
	int cycleLimit;

	// Wired-AND bus of the test node and the DUT
	assign canRx = nodeBit & (outSwitch ? sampleOut : recessive);

	sampleReplayTop #(.dataOffsetBits(16)) UUT (.clk, .resetN, .enable, .canRx, .canId,
		.bitPeriod, .playbackPeriod, .sigWords, .numSigs, .readData, .sampleOut,
		.outSwitch, .rdEn, .addr, .validSigNum, .invalidSignal, .interrupt);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Memory answers a read strobe in the following cycle
	always @(negedge clk) begin
		if (rdPending) begin
			readData = mem[rdAddr];
		end
		rdPending = rdEn;
		rdAddr = addr;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycleLimit) begin
			$display("timeout after %0d cycles, the run did not complete", cycles);
			$display("Verification failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic checkBit(input word_t expWord, input int pos, input logic got);
		if (got !== expWord[pos]) begin
			$display("mismatch at %0t: bit %0d of word %h, got %b", $time, pos, expWord, got);
			errors++;
		end
	endtask

	task automatic checkAddr(input memAddr_t expAddr, input memAddr_t got);
		if (got !== expAddr) begin
			$display("mismatch at %0t: first read address %h, expected %h", $time, got, expAddr);
			errors++;
		end
	endtask

	task automatic checkReport(input sigIndex_t expIdx, input logic expInvalid);
		if (invalidSignal !== expInvalid || (!expInvalid && validSigNum !== expIdx)) begin
			$display("mismatch at %0t: report index %0d invalid %b, expected %0d %b",
				$time, validSigNum, invalidSignal, expIdx, expInvalid);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Bus node
	////////////////////////////////////////////////////////////

	task automatic sendBit(input logic level, input period_t bp, input logic quiet);
		nodeBit = level;
		repeat (bp) begin
			@(negedge clk);
			if (quiet && outSwitch) begin
				$display("outSwitch went high during a decoy frame at %0t", $time);
				errors++;
				quiet = 1'b0;
			end
		end
	endtask

	task automatic sendFrame(input canId_t id, input period_t bp, input logic decoy);
		repeat (11) sendBit(recessive, bp, decoy);
		sendBit(dominant, bp, decoy);
		for (int i = idBits - 1; i >= 0; i--) begin
			sendBit(id[i], bp, decoy);
		end
		// A matching frame leaves the tail to the playback check
		if (decoy) begin
			repeat (fillerBits) sendBit(recessive, bp, 1'b1);
		end
	endtask

	task automatic checkPlayback(input memAddr_t base, input wordCount_t words,
		input period_t pp);
		int hold;
		int total;
		logic sawRead;
		logic fellEarly;
		hold = (pp <= 1) ? 1 : int'(pp);
		total = int'(words) * wordWidth * hold;
		sawRead = 1'b0;
		fellEarly = 1'b0;
		while (!outSwitch) begin
			if (rdEn && !sawRead) begin
				checkAddr(base, addr);
				sawRead = 1'b1;
			end
			@(negedge clk);
		end
		if (!sawRead) begin
			$display("no memory read before playback at %0t", $time);
			errors++;
		end
		for (int c = 0; c <= total; c++) begin
			if (c == total) begin
				if (outSwitch) begin
					$display("outSwitch still high after the last bit at %0t", $time);
					errors++;
				end
			end else begin
				if (!outSwitch && !fellEarly) begin
					$display("outSwitch fell before the last bit at %0t", $time);
					errors++;
					fellEarly = 1'b1;
				end
				// Middle of each held bit
				if (c % hold == hold / 2) begin
					checkBit(mem[base + memAddr_t'(c / (hold * wordWidth))],
						wordWidth - 1 - (c / hold) % wordWidth, sampleOut);
				end
				@(negedge clk);
			end
		end
	endtask

	function automatic int limitFor(input row_t r);
		int hold;
		int bits;
		hold = (r.playbackPeriod <= 1) ? 1 : int'(r.playbackPeriod);
		bits = int'(r.numSigs) * ((r.decoys + 1) * frameBits + errorFlagBits + 3);
		return bits * int'(r.bitPeriod) + int'(r.numSigs) * int'(r.sigWords) * wordWidth * hold;
	endfunction

	////////////////////////////////////////////////////////////
	// Stimulus table and main loop
	////////////////////////////////////////////////////////////

	initial begin
		int k;
		int rowErrors;
		logic accepted;
		void'($urandom(32'h2392_ab3a));
		errors = 0;
		passedRows = 0;
		cycles = 0;
		resetN = 1'b0;
		enable = 1'b0;
		nodeBit = recessive;
		canId = '0;
		bitPeriod = 24'd10;
		playbackPeriod = 24'd1;
		sigWords = 16'd1;
		numSigs = 16'd1;
		readData = '0;
		rdPending = 1'b0;
		rdAddr = '0;
		rows[0] = '{11'h2A5, 16'd3, 16'd1, 24'd10, 24'd3, 1, 16'b100};
		rows[1] = '{11'h135, 16'd2, 16'd2, 24'd12, 24'd0, 0, 16'b000};
		rows[2] = '{11'h4C3, 16'd2, 16'd1, 24'd8, 24'd2, 2, 16'b001};
		cycleLimit = 2000;
		for (int r = 0; r < numRows; r++) begin
			cycleLimit += 2 * limitFor(rows[r]);
		end
		for (int i = 0; i < 32768; i++) begin
			mem[i] = $urandom;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		resetN = 1'b1;
		for (int r = 0; r < numRows; r++) begin
			rowErrors = errors;
			canId = rows[r].id;
			numSigs = rows[r].numSigs;
			sigWords = rows[r].sigWords;
			bitPeriod = rows[r].bitPeriod;
			playbackPeriod = rows[r].playbackPeriod;
			@(negedge clk);
			enable = 1'b1;
			k = 0;
			accepted = 1'b0;
			while (!accepted && k < int'(rows[r].numSigs)) begin
				repeat (rows[r].decoys) sendFrame(canId ^ 11'h100, bitPeriod, 1'b1);
				sendFrame(canId, bitPeriod, 1'b0);
				checkPlayback(memAddr_t'(k * int'(sigWords)), sigWords, playbackPeriod);
				if (rows[r].acceptMask[k]) begin
					accepted = 1'b1;
				end else begin
					// Error flag, then a short recessive pause
					repeat (errorFlagBits) sendBit(dominant, bitPeriod, 1'b0);
					repeat (3) sendBit(recessive, bitPeriod, 1'b0);
					k++;
				end
			end
			while (!interrupt) @(negedge clk);
			checkReport(sigIndex_t'(k), !accepted);
			enable = 1'b0;
			@(negedge clk);
			if (interrupt || outSwitch) begin
				$display("mismatch at %0t: interrupt %b outSwitch %b after enable fell",
					$time, interrupt, outSwitch);
				errors++;
			end
			if (errors == rowErrors) begin
				passedRows++;
				$display("row %0d passed", r);
			end else begin
				$display("row %0d failed with %0d errors", r, errors - rowErrors);
			end
		end
		$display("rows %0d, passed %0d, errors %0d", numRows, passedRows, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== sampleReplayTop.sv ====
module sampleReplayTop import canProtocolPkg::*, replayPkg::*; #(
	parameter int dataOffsetBits = 16
) (
	input logic clk,
	input logic resetN,
	input logic enable,
	input logic canRx,
	input canId_t canId,
	input period_t bitPeriod,
	input period_t playbackPeriod,
	input wordCount_t sigWords,
	input sigIndex_t numSigs,
	input word_t readData,
	output logic sampleOut,
	output logic outSwitch,
	output logic rdEn,
	output memAddr_t addr,
	output sigIndex_t validSigNum,
	output logic invalidSignal,
	output logic interrupt
);

	logic rxBit;
	logic samplePulse;
	logic override;
	logic idleRun;
	logic errorRun;
	logic runClear;
	logic idStart;
	logic idDone;
	logic idMatch;
	logic playStart;
	logic playDone;
	memAddr_t baseAddr;

	////////////////////////////////////////////////////////////
	// Receive side
	////////////////////////////////////////////////////////////

	bitSampler sampler (.clk, .resetN, .canRx, .bitPeriod, .override, .rxBit, .samplePulse);

	// Gap between frames
	runDetector #(.runLength(interframeBits), .runLevel(recessive)) idleDetect (
		.clk, .resetN, .clear(runClear), .rxBit, .samplePulse, .run(idleRun));

	// Error flag after playback
	runDetector #(.runLength(errorFlagBits), .runLevel(dominant)) errorDetect (
		.clk, .resetN, .clear(runClear), .rxBit, .samplePulse, .run(errorRun));

	idComparator idCompare (.clk, .resetN, .start(idStart), .rxBit, .samplePulse, .canId,
		.done(idDone), .match(idMatch));

	////////////////////////////////////////////////////////////
	// Playback and control
	////////////////////////////////////////////////////////////

	playbackUnit playback (.clk, .resetN, .start(playStart), .baseAddr, .sigWords,
		.playbackPeriod, .readData, .rdEn, .addr, .sampleOut, .outSwitch, .done(playDone));

	replaySequencer #(.dataOffsetBits(dataOffsetBits)) sequencer (
		.clk, .resetN, .enable, .numSigs, .sigWords, .samplePulse, .rxBit, .idleRun,
		.errorRun, .idDone, .idMatch, .playDone, .idStart, .runClear, .playStart,
		.override, .baseAddr, .validSigNum, .invalidSignal, .interrupt);

endmodule

// ==== sampleReplay_sva.sv ====
module sampleReplaySva (
	input logic clk,
	input logic resetN,
	input logic enable,
	input logic rdEn,
	input logic outSwitch,
	input logic interrupt
);

	////////////////////////////////////////////////////////////
	// Top level protocol properties
	////////////////////////////////////////////////////////////

	// No memory traffic once the result is out
	noReadInReport: assert property (@(posedge clk) disable iff (!resetN)
		interrupt |-> !rdEn)
		else $error("rdEn high while interrupt is high");

	outSwitchAfterReset: assert property (@(posedge clk)
		!resetN |=> !outSwitch)
		else $error("outSwitch high after reset");

	// Result holds until enable drops
	interruptHeld: assert property (@(posedge clk) disable iff (!resetN)
		(interrupt && enable) |=> interrupt)
		else $error("interrupt fell while enable was high");

endmodule

bind sampleReplayTop sampleReplaySva sva (.clk, .resetN, .enable, .rdEn, .outSwitch,
	.interrupt);
